//--- Bender.yml
package:
  name: single_cpu

sources:
  - hw/rv_isa_pkg.sv
  - hw/cpu_cfg_pkg.sv
  - hw/inst_q_if.sv
  - hw/fetch_unit.sv
  - hw/inst_queue.sv
  - hw/reg_file.sv
  - hw/exec_unit.sv
  - hw/single_cpu_top.sv
  - target: simulation
    files:
      - sim/cpu_tb.sv

//--- hw/cpu_cfg_pkg.sv
package cpu_cfg_pkg;

    localparam int xlen      = 32;                 // Data and instruction width
    localparam int reg_idx_w = 5;

    typedef logic [xlen-1:0]      word_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // One fetched instruction with its address
    typedef struct packed {
        word_t pc;
        word_t inst;
    } q_entry_t;

endpackage

//--- hw/exec_unit.sv
`timescale 1ns/1ps

module exec_unit
    import rv_isa_pkg::*;
    import cpu_cfg_pkg::*;
#(
    parameter int DMEM_DEPTH = 64
) (
    input  logic       CLK,
    input  logic       RST,
    inst_q_if.consumer q,
    output reg_idx_t   rs1,
    output reg_idx_t   rs2,
    input  word_t      rd1,
    input  word_t      rd2,
    output logic       rf_we,
    output reg_idx_t   rf_wr,
    output word_t      rf_wd,
    output logic       retire_valid,
    output word_t      retire_pc,
    output reg_idx_t   retire_rd,
    output logic       retire_we,
    output word_t      retire_value,
    output logic       halted
);

    localparam int DW = $clog2(DMEM_DEPTH);

    word_t      dmem [DMEM_DEPTH];
    word_t      inst;
    opcode_e    opcode;
    funct3_e    funct3;
    alu_op_e    alu_op;
    reg_idx_t   rd_idx;
    logic [11:0] imm12;
    word_t      imm;
    word_t      op_b;
    word_t      alu_res;
    word_t      load_data;
    logic       do_pop;
    logic       is_halt;
    logic       exec_ok;
    logic       is_store;
    logic       writes_rd;

    assign inst   = q.pop_entry.inst;
    assign opcode = opcode_e'(inst[OPC_MSB:OPC_LSB]);
    assign funct3 = funct3_e'(inst[F3_MSB:F3_LSB]);
    assign rd_idx = inst[RD_MSB:RD_LSB];
    assign rs1    = inst[RS1_MSB:RS1_LSB];
    assign rs2    = inst[RS2_MSB:RS2_LSB];

    // S-type splits the immediate around rd
    assign is_store = (opcode == OP_STORE);
    assign imm12    = is_store ? {inst[IMM_MSB:F7_LSB], inst[RD_MSB:RD_LSB]}
                               : inst[IMM_MSB:IMM_I_LSB];
    assign imm      = {{(xlen-12){imm12[11]}}, imm12};
    assign op_b     = (opcode == OP_R) ? rd2 : imm;

    always_comb begin
        alu_op = ALU_PASS;
        case (opcode)
            OP_R, OP_IMM: begin
                case (funct3)
                    F3_ADD_SUB: alu_op = (opcode == OP_R && inst[ALT_BIT]) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     alu_op = ALU_SLL;
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_SLTU:    alu_op = ALU_SLTU;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_SRL_SRA: alu_op = inst[ALT_BIT] ? ALU_SRA : ALU_SRL;
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                    default:    alu_op = ALU_PASS;
                endcase
            end
            OP_LOAD, OP_STORE: alu_op = ALU_ADD;   // Effective address
            default:           alu_op = ALU_PASS;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_res = rd1 + op_b;
            ALU_SUB:  alu_res = rd1 - op_b;
            ALU_SLL:  alu_res = rd1 << op_b[4:0];
            ALU_SLT:  alu_res = {31'd0, $signed(rd1) < $signed(op_b)};
            ALU_SLTU: alu_res = {31'd0, rd1 < op_b};
            ALU_XOR:  alu_res = rd1 ^ op_b;
            ALU_SRL:  alu_res = rd1 >> op_b[4:0];
            ALU_SRA:  alu_res = word_t'($signed(rd1) >>> op_b[4:0]);
            ALU_OR:   alu_res = rd1 | op_b;
            ALU_AND:  alu_res = rd1 & op_b;
            default:  alu_res = op_b;
        endcase
    end

    assign load_data = dmem[alu_res[DW+1:2]];     // Word address wraps on depth

    assign do_pop    = !q.empty && !halted;
    assign q.pop     = do_pop;
    assign is_halt   = (inst == halt_word);
    assign exec_ok   = do_pop && !is_halt;
    assign writes_rd = (opcode == OP_R) || (opcode == OP_IMM) || (opcode == OP_LOAD);

    assign rf_we = exec_ok && writes_rd && (rd_idx != '0);
    assign rf_wr = rd_idx;
    assign rf_wd = (opcode == OP_LOAD) ? load_data : alu_res;

    always_ff @(posedge CLK) begin
        if (exec_ok && is_store) begin
            dmem[alu_res[DW+1:2]] <= rd2;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            retire_valid <= 1'b0;
            halted       <= 1'b0;
        end else begin
            retire_valid <= exec_ok;
            if (do_pop && is_halt) halted <= 1'b1;
        end
    end

    // Stores report rd as x0 and the stored data
    always_ff @(posedge CLK) begin
        if (exec_ok) begin
            retire_pc    <= q.pop_entry.pc;
            retire_rd    <= is_store ? '0 : rd_idx;
            retire_we    <= writes_rd && (rd_idx != '0);
            retire_value <= is_store ? rd2 : rf_wd;
        end
    end

    // Anything outside the subset would retire as a silent pass
    a_known_opcode: assert property (@(posedge CLK) disable iff (RST)
        exec_ok |-> (opcode inside {OP_R, OP_IMM, OP_LOAD, OP_STORE}));

endmodule

//--- hw/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
    import rv_isa_pkg::*;
    import cpu_cfg_pkg::*;
#(
    parameter int IMEM_DEPTH = 64
) (
    input  logic       CLK,
    input  logic       RST,
    input  logic       run,
    input  logic       imem_we,
    input  word_t      imem_addr,                  // Byte address with the low two bits ignored
    input  word_t      imem_wdata,
    inst_q_if.producer q
);

    localparam int IW = $clog2(IMEM_DEPTH);

    word_t  imem [IMEM_DEPTH];
    word_t  pc;
    word_t  inst;
    logic   stopped;

    // Program load port
    always_ff @(posedge CLK) begin
        if (imem_we) begin
            imem[imem_addr[IW+1:2]] <= imem_wdata;
        end
    end

    assign inst = imem[pc[IW+1:2]];                // Combinational read

    assign q.push       = run && !q.full && !stopped;
    assign q.push_entry = '{pc: pc, inst: inst};

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc      <= '0;
            stopped <= 1'b0;
        end else if (q.push) begin
            pc <= pc + 32'd4;
            if (inst == halt_word) begin
                stopped <= 1'b1;                   // Held until reset
            end
        end
    end

    // A program without a halt word runs off the end of memory
    a_pc_in_imem: assert property (@(posedge CLK) disable iff (RST)
        q.push |-> (pc < IMEM_DEPTH * 4));

endmodule

//--- hw/inst_q_if.sv
`timescale 1ns/1ps

interface inst_q_if import cpu_cfg_pkg::*; ();

    logic     push;
    q_entry_t push_entry;
    logic     full;
    logic     pop;
    q_entry_t pop_entry;                           // Head entry, valid while empty is low
    logic     empty;

    modport producer (output push, output push_entry, input full);

    modport queue (input push, input push_entry, input pop,
                   output full, output empty, output pop_entry);

    modport consumer (output pop, input empty, input pop_entry);

endinterface

//--- hw/inst_queue.sv
`timescale 1ns/1ps

module inst_queue
    import cpu_cfg_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4                  // Power of two
) (
    input  logic    CLK,
    input  logic    RST,
    inst_q_if.queue q
);

    localparam int PW = $clog2(QUEUE_DEPTH);

    q_entry_t        buf_mem [QUEUE_DEPTH];
    logic [PW-1:0]   wptr;
    logic [PW-1:0]   rptr;
    logic [PW:0]     count;
    logic            do_push;
    logic            do_pop;

    assign q.full      = (count == QUEUE_DEPTH[PW:0]);
    assign q.empty     = (count == '0);
    assign q.pop_entry = buf_mem[rptr];

    assign do_push = q.push && !q.full;
    assign do_pop  = q.pop && !q.empty;

    always_ff @(posedge CLK) begin
        if (do_push) begin
            buf_mem[wptr] <= q.push_entry;
        end
    end

    // Pointers wrap on their own width
    always_ff @(posedge CLK) begin
        if (RST) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_push) wptr <= wptr + 1'b1;
            if (do_pop)  rptr <= rptr + 1'b1;
            count <= count + (do_push ? 1'b1 : 1'b0) - (do_pop ? 1'b1 : 1'b0);
        end
    end

    a_no_push_full: assert property (@(posedge CLK) disable iff (RST)
        q.push |-> !q.full);

    a_no_pop_empty: assert property (@(posedge CLK) disable iff (RST)
        q.pop |-> !q.empty);

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ps

module reg_file
    import cpu_cfg_pkg::*;
(
    input  logic     CLK,
    input  logic     RST,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rd1,
    output word_t    rd2,
    input  logic     we,
    input  reg_idx_t wr,
    input  word_t    wd
);

    word_t regs [32];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr != '0)) begin   // x0 is never written
            regs[wr] <= wd;
        end
    end

    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_R     = 7'b0110011,
        OP_IMM   = 7'b0010011,
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_PASS                                   // Result is operand b
    } alu_op_e;

    // Instruction field positions
    localparam int OPC_LSB   = 0;
    localparam int OPC_MSB   = 6;
    localparam int RD_LSB    = 7;
    localparam int RD_MSB    = 11;
    localparam int F3_LSB    = 12;
    localparam int F3_MSB    = 14;
    localparam int RS1_LSB   = 15;
    localparam int RS1_MSB   = 19;
    localparam int RS2_LSB   = 20;
    localparam int RS2_MSB   = 24;
    localparam int F7_LSB    = 25;
    localparam int ALT_BIT   = 30;                 // SUB and SRA select
    localparam int IMM_I_LSB = 20;
    localparam int IMM_MSB   = 31;

    localparam logic [31:0] halt_word = 32'h0000_0000; // Ends a program

endpackage

//--- hw/single_cpu_top.sv
`timescale 1ns/1ps

module single_cpu_top
    import cpu_cfg_pkg::*;
#(
    parameter int IMEM_DEPTH  = 64,
    parameter int DMEM_DEPTH  = 64,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic     CLK,
    input  logic     RST,
    input  logic     run,
    input  logic     imem_we,
    input  word_t    imem_addr,
    input  word_t    imem_wdata,
    output logic     retire_valid,
    output word_t    retire_pc,
    output reg_idx_t retire_rd,
    output logic     retire_we,
    output word_t    retire_value,
    output logic     halted
);

    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rd1;
    word_t    rd2;
    logic     rf_we;
    reg_idx_t rf_wr;
    word_t    rf_wd;

    inst_q_if q_if ();

    fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) fetch0 (
        .CLK(CLK), .RST(RST), .run(run), .imem_we(imem_we),
        .imem_addr(imem_addr), .imem_wdata(imem_wdata), .q(q_if.producer)
    );

    inst_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue0 (
        .CLK(CLK), .RST(RST), .q(q_if.queue)
    );

    reg_file rf0 (
        .CLK(CLK), .RST(RST), .rs1(rs1), .rs2(rs2), .rd1(rd1), .rd2(rd2),
        .we(rf_we), .wr(rf_wr), .wd(rf_wd)
    );

    exec_unit #(.DMEM_DEPTH(DMEM_DEPTH)) exec0 (
        .CLK(CLK), .RST(RST), .q(q_if.consumer),
        .rs1(rs1), .rs2(rs2), .rd1(rd1), .rd2(rd2),
        .rf_we(rf_we), .rf_wr(rf_wr), .rf_wd(rf_wd),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_we(retire_we), .retire_value(retire_value), .halted(halted)
    );

endmodule

//--- project.f
hw/rv_isa_pkg.sv
hw/cpu_cfg_pkg.sv
hw/inst_q_if.sv
hw/fetch_unit.sv
hw/inst_queue.sv
hw/reg_file.sv
hw/exec_unit.sv
hw/single_cpu_top.sv
sim/cpu_tb.sv

//--- sim/cpu_golden.txt
# Section one: program word count, then one instruction word per line in hex
# Section two: expected retire records as pc (hex), rd (dec), retire_we (dec), value (hex)
33
00700093 addi x1, x0, 7
ffd00113 addi x2, x0, -3
002081b3 add  x3, x1, x2
40110233 sub  x4, x2, x1
003092b3 sll  x5, x1, x3
00112333 slt  x6, x2, x1
001133b3 sltu x7, x2, x1
0020c433 xor  x8, x1, x2
001154b3 srl  x9, x2, x1
40325533 sra  x10, x4, x3
0040e5b3 or   x11, x1, x4
0020f633 and  x12, x1, x2
ffe12693 slti  x13, x2, -2
fff0b713 sltiu x14, x1, -1
fff0c793 xori  x15, x1, -1
ff00e813 ori   x16, x1, -16
ff817893 andi  x17, x2, -8
01f09913 slli  x18, x1, 31
01f95993 srli  x19, x18, 31
41f95a13 srai  x20, x18, 31
40125a93 srai  x21, x4, 1
00009b13 slli  x22, x1, 0
00115b93 srli  x23, x2, 1
00508013 addi  x0, x1, 5
00100c33 add   x24, x0, x1
00402423 sw    x4, 8(x0)
00102623 sw    x1, 12(x0)
00802c83 lw    x25, 8(x0)
00202423 sw    x2, 8(x0)
0050ad03 lw    x26, 5(x1)
00802d83 lw    x27, 8(x0)
001d8e13 addi  x28, x27, 1
00000000 halt
00000000 1 1 00000007
00000004 2 1 fffffffd
00000008 3 1 00000004
0000000c 4 1 fffffff6
00000010 5 1 00000070
00000014 6 1 00000001
00000018 7 1 00000000
0000001c 8 1 fffffffa
00000020 9 1 01ffffff
00000024 10 1 ffffffff
00000028 11 1 fffffff7
0000002c 12 1 00000005
00000030 13 1 00000001
00000034 14 1 00000001
00000038 15 1 fffffff8
0000003c 16 1 fffffff7
00000040 17 1 fffffff8
00000044 18 1 80000000
00000048 19 1 00000001
0000004c 20 1 ffffffff
00000050 21 1 fffffffb
00000054 22 1 00000007
00000058 23 1 7ffffffe
0000005c 0 0 0000000c
00000060 24 1 00000007
00000064 0 0 fffffff6
00000068 0 0 00000007
0000006c 25 1 fffffff6
00000070 0 0 fffffffd
00000074 26 1 00000007
00000078 27 1 fffffffd
0000007c 28 1 fffffffe

//--- sim/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

    localparam int HALT_TIMEOUT = 1000;            // Cycles allowed per program run
    localparam int QUIET_CYCLES = 20;

    logic        CLK = 1'b0;
    logic        RST;
    logic        run;
    logic        imem_we;
    logic [31:0] imem_addr;
    logic [31:0] imem_wdata;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic        retire_we;
    logic [31:0] retire_value;
    logic        halted;

    logic [31:0] prog[$];
    logic [31:0] exp_pc[$];
    logic [4:0]  exp_rd[$];
    logic        exp_we[$];
    logic [31:0] exp_val[$];

    integer seed = 32'h6e04;
    int     value_errs = 0;
    int     other_errs = 0;
    int     rec_idx = 0;
    int     rec_total = 0;
    logic   check_en = 1'b0;
    logic   file_ok;
    string  test_name = "none";

    single_cpu_top dut0 (
        .CLK(CLK), .RST(RST), .run(run), .imem_we(imem_we),
        .imem_addr(imem_addr), .imem_wdata(imem_wdata),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_we(retire_we), .retire_value(retire_value), .halted(halted)
    );

    always #5 CLK = ~CLK;

    // Program words first, then retire records; lines starting with # are skipped
    task automatic read_golden();
        int          fd;
        int          state;
        int          word_cnt;
        int          rd;
        int          we;
        string       line;
        logic [31:0] w;
        logic [31:0] pc;
        logic [31:0] val;
        state   = 0;
        file_ok = 1'b0;
        fd = $fopen("sim/cpu_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file sim/cpu_golden.txt");
            other_errs++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line[0] == 8'h23 || line[0] == 8'h0a) continue;
            if (state == 0) begin
                if ($sscanf(line, "%d", word_cnt) == 1) state = 1;
            end else if (state == 1) begin
                if ($sscanf(line, "%h", w) == 1) prog.push_back(w);
                if (prog.size() == word_cnt) state = 2;
            end else if ($sscanf(line, "%h %d %d %h", pc, rd, we, val) == 4) begin
                exp_pc.push_back(pc);
                exp_rd.push_back(rd[4:0]);
                exp_we.push_back(we[0]);
                exp_val.push_back(val);
            end
        end
        $fclose(fd);
        file_ok = (state == 2) && (exp_pc.size() > 0);
        if (!file_ok) begin
            $display("Golden file is incomplete, no records were read");
            other_errs++;
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            @(negedge CLK);
            imem_we    = 1'b1;
            imem_addr  = i * 4;                    // Byte address
            imem_wdata = prog[i];
        end
        @(negedge CLK);
        imem_we = 1'b0;
    endtask

    task automatic compare_field(string field, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s record %0d %s: expected %h actual %h",
                     test_name, rec_idx, field, expected, actual);
            value_errs++;
        end
    endtask

    // One full program run with run held high or toggled at random
    task automatic run_program(string name, bit toggle_run);
        int cycles;
        run = 1'b0;
        RST = 1'b1;
        repeat (2) @(negedge CLK);
        RST = 1'b0;
        load_program();
        test_name = name;
        rec_idx   = 0;
        check_en  = 1'b1;
        run       = 1'b1;
        cycles    = 0;
        while (!halted && cycles < HALT_TIMEOUT) begin
            @(negedge CLK);
            if (toggle_run) run = ($random(seed) & 3) != 0;  // High three cycles in four
            cycles++;
        end
        if (!halted) begin
            $display("Timeout in %s, halted did not rise within %0d cycles",
                     name, HALT_TIMEOUT);
            other_errs++;
        end
        repeat (QUIET_CYCLES) @(negedge CLK);      // Any retire here is flagged by the monitor
        run = 1'b0;
        @(posedge CLK);                            // Monitor has seen the last quiet cycle
        check_en = 1'b0;
        if (rec_idx != exp_pc.size()) begin
            $display("Fail %s retire count: expected %0d actual %0d",
                     name, exp_pc.size(), rec_idx);
            value_errs++;
        end
        @(negedge CLK);
    endtask

    // Outputs change on the rising edge, sampled here on the falling one
    always @(negedge CLK) begin
        if (check_en && retire_valid) begin
            if (rec_idx >= exp_pc.size()) begin
                $display("Retire pulse in %s at pc %h after the last golden record",
                         test_name, retire_pc);
                other_errs++;
            end else begin
                compare_field("pc", exp_pc[rec_idx], retire_pc);
                compare_field("rd", {27'd0, exp_rd[rec_idx]}, {27'd0, retire_rd});
                compare_field("we", {31'd0, exp_we[rec_idx]}, {31'd0, retire_we});
                compare_field("value", exp_val[rec_idx], retire_value);
            end
            rec_idx++;
            rec_total++;
        end
    end

    initial begin
        RST        = 1'b1;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        read_golden();
        if (file_ok) begin
            run_program("steady_run", 1'b0);
            run_program("random_run", 1'b1);
        end
        $display("Retired %0d records, %0d value errors, %0d other errors",
                 rec_total, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
